// File: build.f
+incdir+test
common/noc_pkg.sv
common/router_pkg.sv
hw/input_port/xy_route.sv
hw/input_port/input_port.sv
hw/switch_alloc.sv
hw/crossbar.sv
hw/credit_release_gen.sv
hw/router_two_stage.sv
test/router_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the router testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module router_tb -f build.f -o router_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/router_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

if echo "$out" | grep -q "PASS: all tests"; then
    exit 0
fi
exit 1

// File: test/router_tb_tasks.svh
function automatic logic [W-1:0] make_flit(noc_pkg::flit_type_e t, int dx, int dy);
    logic [W-1:0] f;
    f = '0;
    f[noc_pkg::TYPE_LSB +: noc_pkg::TYPE_W] = t;
    f[noc_pkg::DX_LSB +: noc_pkg::COORD_W] = noc_pkg::COORD_W'(dx);
    f[noc_pkg::DY_LSB +: noc_pkg::COORD_W] = noc_pkg::COORD_W'(dy);
    f[noc_pkg::PAYLOAD_W-1:0] = noc_pkg::PAYLOAD_W'($random(seed));
    return f;
endfunction

task automatic clear_logs();
    out_port_q.delete();
    out_flit_q.delete();
    out_cyc_q.delete();
    cred_port_q.delete();
    cred_cyc_q.delete();
endtask

task automatic report_error(string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    errors++;
endtask

task automatic finish_test(string name, int err_start);
    if (errors == err_start) begin
        $display("%s: passed", name);
    end else begin
        $display("%s: failed", name);
        tests_failed++;
    end
endtask

task automatic wait_outputs(int n, int limit);
    int waited;
    waited = 0;
    while (out_port_q.size() < n && waited < limit) begin
        @(posedge clk);
        waited++;
    end
    if (out_port_q.size() < n) begin
        $display("flits missing: expected %0d, saw %0d", n, out_port_q.size());
        errors++;
    end
endtask

task automatic send_flit(int port, logic [W-1:0] f, output int sent_cycle);
    @(negedge clk);
    flit_in[port] = f;
    flit_in_wr[port] = 1'b1;
    sent_cycle = cycle;
    @(negedge clk);
    flit_in_wr[port] = 1'b0;
endtask

task automatic test_reset_state();
    int err_start;
    err_start = errors;
    clear_logs();
    repeat (5) @(posedge clk);
    if (out_port_q.size() != 0) report_error("flit_out_wr high after reset");
    if (cred_port_q.size() != 0) report_error("credit_out high after reset");
    finish_test("test 1 reset state", err_start);
endtask

task automatic test_single_latency();
    int err_start;
    int sent;
    logic [W-1:0] f;
    err_start = errors;
    clear_logs();
    f = make_flit(noc_pkg::FLIT_SINGLE, 5, 3);
    send_flit(noc_pkg::PORT_LOCAL, f, sent);
    wait_outputs(1, 10);
    repeat (2) @(posedge clk);
    if (out_port_q.size() != 1 || out_port_q[0] != noc_pkg::PORT_EAST || out_flit_q[0] != f)
        report_error("single flit not seen once on east with its value");
    else if (out_cyc_q[0] != sent + 2)
        report_error($sformatf("latency %0d, expected 2", out_cyc_q[0] - sent));
    if (cred_port_q.size() != 1 || cred_port_q[0] != noc_pkg::PORT_LOCAL
        || cred_cyc_q[0] != sent + 2)
        report_error("credit_out on local not in the output cycle");
    finish_test("test 2 single-flit latency", err_start);
endtask

task automatic test_xy_routing();
    int err_start;
    int sent;
    int dx [7] = '{5, 1, 3, 3, 3, 6, 0};
    int dy [7] = '{3, 3, 6, 0, 3, 0, 7};
    // router at (3,3) corrects x before y
    int exp_port [7] = '{noc_pkg::PORT_EAST, noc_pkg::PORT_WEST, noc_pkg::PORT_NORTH,
                         noc_pkg::PORT_SOUTH, noc_pkg::PORT_LOCAL, noc_pkg::PORT_EAST,
                         noc_pkg::PORT_WEST};
    logic [W-1:0] f;
    err_start = errors;
    for (int k = 0; k < 7; k++) begin
        clear_logs();
        f = make_flit(noc_pkg::FLIT_SINGLE, dx[k], dy[k]);
        send_flit(noc_pkg::PORT_LOCAL, f, sent);
        wait_outputs(1, 10);
        repeat (2) @(posedge clk);
        if (out_port_q.size() != 1 || out_flit_q[0] != f)
            report_error($sformatf("dest (%0d,%0d) flit lost or changed", dx[k], dy[k]));
        else if (out_port_q[0] != exp_port[k])
            report_error($sformatf("dest (%0d,%0d) left on port %0d, expected %0d",
                                   dx[k], dy[k], out_port_q[0], exp_port[k]));
    end
    finish_test("test 3 XY routing", err_start);
endtask

task automatic test_wormhole();
    int err_start;
    logic [W-1:0] pkt_w [4];
    logic [W-1:0] pkt_s [4];
    logic [W-1:0] exp_q [$];
    noc_pkg::flit_type_e types [4];
    int cred_cnt [P];
    err_start = errors;
    clear_logs();
    types = '{noc_pkg::FLIT_HEAD, noc_pkg::FLIT_BODY, noc_pkg::FLIT_BODY, noc_pkg::FLIT_TAIL};
    for (int k = 0; k < 4; k++) begin
        pkt_w[k] = make_flit(types[k], 6, 3);
        pkt_s[k] = make_flit(types[k], 7, 3);
    end
    // both inputs push one flit per cycle together
    for (int k = 0; k < 4; k++) begin
        @(negedge clk);
        flit_in[noc_pkg::PORT_WEST] = pkt_w[k];
        flit_in[noc_pkg::PORT_SOUTH] = pkt_s[k];
        flit_in_wr[noc_pkg::PORT_WEST] = 1'b1;
        flit_in_wr[noc_pkg::PORT_SOUTH] = 1'b1;
    end
    @(negedge clk);
    flit_in_wr = '0;
    wait_outputs(8, 40);
    repeat (3) @(posedge clk);
    if (out_port_q.size() == 8) begin
        if (out_flit_q[0] == pkt_w[0]) begin
            for (int k = 0; k < 4; k++) exp_q.push_back(pkt_w[k]);
            for (int k = 0; k < 4; k++) exp_q.push_back(pkt_s[k]);
        end else begin
            for (int k = 0; k < 4; k++) exp_q.push_back(pkt_s[k]);
            for (int k = 0; k < 4; k++) exp_q.push_back(pkt_w[k]);
        end
        for (int k = 0; k < 8; k++) begin
            if (out_port_q[k] != noc_pkg::PORT_EAST || out_flit_q[k] != exp_q[k])
                report_error($sformatf("flit %0d on east out of packet order", k));
        end
    end else begin
        report_error($sformatf("saw %0d flits, expected 8", out_port_q.size()));
    end
    // one credit back upstream per flit that left each input
    for (int p = 0; p < P; p++) cred_cnt[p] = 0;
    for (int k = 0; k < cred_port_q.size(); k++) cred_cnt[cred_port_q[k]]++;
    if (cred_cnt[noc_pkg::PORT_WEST] != 4 || cred_cnt[noc_pkg::PORT_SOUTH] != 4
        || cred_cnt[noc_pkg::PORT_LOCAL] + cred_cnt[noc_pkg::PORT_EAST]
           + cred_cnt[noc_pkg::PORT_NORTH] != 0)
        report_error($sformatf("credit_out pulses west %0d south %0d, expected 4 each",
                               cred_cnt[noc_pkg::PORT_WEST], cred_cnt[noc_pkg::PORT_SOUTH]));
    finish_test("test 4 wormhole", err_start);
endtask

task automatic test_back_pressure();
    int err_start;
    int sent;
    logic [W-1:0] sent_q [$];
    err_start = errors;
    clear_logs();
    hold_credit[noc_pkg::PORT_EAST] = 1'b1;
    for (int k = 0; k < router_pkg::BUF_DEPTH + 2; k++) begin
        sent_q.push_back(make_flit(noc_pkg::FLIT_SINGLE, 7, 1));
        send_flit(noc_pkg::PORT_LOCAL, sent_q[k], sent);
    end
    repeat (20) @(posedge clk);
    if (out_port_q.size() != router_pkg::BUF_DEPTH)
        report_error($sformatf("%0d flits passed with no credits back, expected %0d",
                               out_port_q.size(), router_pkg::BUF_DEPTH));
    @(negedge clk);
    manual_credit[noc_pkg::PORT_EAST] = 1'b1;  // two credit pulses
    repeat (2) @(negedge clk);
    manual_credit[noc_pkg::PORT_EAST] = 1'b0;
    wait_outputs(router_pkg::BUF_DEPTH + 2, 20);
    repeat (5) @(posedge clk);
    if (out_port_q.size() != router_pkg::BUF_DEPTH + 2) begin
        report_error("wrong flit count after two credits");
    end else begin
        for (int k = 0; k < router_pkg::BUF_DEPTH + 2; k++) begin
            if (out_port_q[k] != noc_pkg::PORT_EAST || out_flit_q[k] != sent_q[k])
                report_error($sformatf("back-pressure flit %0d wrong", k));
        end
    end
    // give back the credits the downstream node still owes
    @(negedge clk);
    manual_credit[noc_pkg::PORT_EAST] = 1'b1;
    repeat (router_pkg::BUF_DEPTH) @(negedge clk);
    manual_credit[noc_pkg::PORT_EAST] = 1'b0;
    hold_credit[noc_pkg::PORT_EAST] = 1'b0;
    finish_test("test 5 back-pressure", err_start);
endtask

task automatic test_credit_release();
    int err_start;
    int req;
    err_start = errors;
    clear_logs();
    @(negedge clk);
    credit_release_en[noc_pkg::PORT_LOCAL] = 1'b1;
    req = cycle;
    @(negedge clk);
    credit_release_en[noc_pkg::PORT_LOCAL] = 1'b0;
    repeat (router_pkg::CREDIT_NUM + 4) @(posedge clk);
    if (cred_port_q.size() != router_pkg::CREDIT_NUM) begin
        report_error($sformatf("%0d release pulses, expected %0d",
                               cred_port_q.size(), router_pkg::CREDIT_NUM));
    end else begin
        for (int k = 0; k < router_pkg::CREDIT_NUM; k++) begin
            if (cred_port_q[k] != noc_pkg::PORT_LOCAL || cred_cyc_q[k] != req + 1 + k)
                report_error($sformatf("release pulse %0d at wrong port or cycle", k));
        end
    end
    finish_test("test 6 credit release", err_start);
endtask

// File: test/router_tb.sv
`timescale 1ns/100ps
`default_nettype none

module router_tb;

    localparam int PERIOD = 40;
    localparam int NUM_TESTS = 6;
    localparam int TEST_CYCLES = 150;  // generous upper bound per test
    localparam int P = noc_pkg::P;
    localparam int W = noc_pkg::FLIT_W;

    logic                        clk = 1'b0;
    logic                        reset;
    logic [noc_pkg::COORD_W-1:0] cur_x;
    logic [noc_pkg::COORD_W-1:0] cur_y;
    logic [W-1:0]                flit_in [P];
    logic [P-1:0]                flit_in_wr;
    logic [P-1:0]                credit_out;
    logic [W-1:0]                flit_out [P];
    logic [P-1:0]                flit_out_wr;
    logic [P-1:0]                credit_in;
    logic [P-1:0]                credit_release_en;

    logic [P-1:0] model_credit;   // downstream nodes
    logic [P-1:0] manual_credit;  // driven by the back-pressure test
    logic [P-1:0] hold_credit;
    logic [P-1:0] last_wr;
    int           cycle;
    int           errors;
    int           tests_failed;
    int           seed;

    // observed traffic, one entry per pulse
    int           out_port_q [$];
    logic [W-1:0] out_flit_q [$];
    int           out_cyc_q [$];
    int           cred_port_q [$];
    int           cred_cyc_q [$];

    assign credit_in = model_credit | manual_credit;

    router_two_stage dut_i (
        .clk               (clk),
        .reset             (reset),
        .cur_x             (cur_x),
        .cur_y             (cur_y),
        .flit_in           (flit_in),
        .flit_in_wr        (flit_in_wr),
        .credit_out        (credit_out),
        .flit_out          (flit_out),
        .flit_out_wr       (flit_out_wr),
        .credit_in         (credit_in),
        .credit_release_en (credit_release_en)
    );

    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // sample mid-cycle, credits go back one cycle after each flit
    always @(negedge clk) begin
        for (int p = 0; p < P; p++) begin
            if (flit_out_wr[p]) begin
                out_port_q.push_back(p);
                out_flit_q.push_back(flit_out[p]);
                out_cyc_q.push_back(cycle);
            end
            if (credit_out[p]) begin
                cred_port_q.push_back(p);
                cred_cyc_q.push_back(cycle);
            end
        end
        model_credit = last_wr;
        last_wr = flit_out_wr & ~hold_credit;
    end

    `include "router_tb_tasks.svh"

    initial begin
        #(NUM_TESTS * TEST_CYCLES * PERIOD);
        $display("timeout: the tests did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        reset = 1'b1;
        cur_x = 3'd3;
        cur_y = 3'd3;
        flit_in_wr = '0;
        credit_release_en = '0;
        for (int p = 0; p < P; p++) flit_in[p] = '0;
        model_credit = '0;
        manual_credit = '0;
        hold_credit = '0;
        last_wr = '0;
        cycle = 0;
        errors = 0;
        tests_failed = 0;
        seed = 81422;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_single_latency();
        test_xy_routing();
        test_wormhole();
        test_back_pressure();
        test_credit_release();

        $display("tests run %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/router_two_stage.sv
`timescale 1ns/100ps
`default_nettype none

module router_two_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [noc_pkg::COORD_W-1:0] cur_x,
    input  logic [noc_pkg::COORD_W-1:0] cur_y,
    input  logic [noc_pkg::FLIT_W-1:0]  flit_in [noc_pkg::P],
    input  logic [noc_pkg::P-1:0]       flit_in_wr,
    output logic [noc_pkg::P-1:0]       credit_out,
    output logic [noc_pkg::FLIT_W-1:0]  flit_out [noc_pkg::P],
    output logic [noc_pkg::P-1:0]       flit_out_wr,
    input  logic [noc_pkg::P-1:0]       credit_in,
    input  logic [noc_pkg::P-1:0]       credit_release_en
);

    logic [noc_pkg::P-1:0]      req_valid;
    noc_pkg::port_e             req_port [noc_pkg::P];
    logic [noc_pkg::P-1:0]      req_tail;
    logic [noc_pkg::FLIT_W-1:0] front_flit [noc_pkg::P];
    logic [noc_pkg::P-1:0]      grant [noc_pkg::P];  // per output, one-hot input
    logic [noc_pkg::P-1:0]      pop;
    logic [noc_pkg::P-1:0]      credit_pulse;
    logic [noc_pkg::P-1:0]      release_pulse;

    for (genvar i = 0; i < noc_pkg::P; i++) begin : g_port
        input_port in_i (
            .clk          (clk),
            .reset        (reset),
            .cur_x        (cur_x),
            .cur_y        (cur_y),
            .flit_in      (flit_in[i]),
            .flit_in_wr   (flit_in_wr[i]),
            .pop          (pop[i]),
            .req_valid    (req_valid[i]),
            .req_port     (req_port[i]),
            .req_tail     (req_tail[i]),
            .front_flit   (front_flit[i]),
            .credit_pulse (credit_pulse[i])
        );

        // only a local endpoint ever raises the release request
        credit_release_gen release_i (
            .clk        (clk),
            .reset      (reset),
            .en         (credit_release_en[i]),
            .credit_out (release_pulse[i])
        );
    end

    // stage 1: route and allocation
    switch_alloc alloc_i (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_port  (req_port),
        .req_tail  (req_tail),
        .credit_in (credit_in),
        .grant     (grant),
        .pop       (pop)
    );

    // stage 2: traversal
    crossbar xbar_i (
        .clk         (clk),
        .reset       (reset),
        .grant       (grant),
        .front_flit  (front_flit),
        .flit_out    (flit_out),
        .flit_out_wr (flit_out_wr)
    );

    assign credit_out = credit_pulse | release_pulse;

endmodule

`default_nettype wire

// File: hw/credit_release_gen.sv
`timescale 1ns/100ps
`default_nettype none

module credit_release_gen (
    input  logic clk,
    input  logic reset,
    input  logic en,
    output logic credit_out
);

    logic [router_pkg::CREDIT_W-1:0] counter;
    logic                            counter_is_zero;
    logic                            counter_is_max;
    logic                            counter_incr;

    assign counter_is_zero = (counter == '0);
    assign counter_is_max = (counter == router_pkg::CREDIT_W'(router_pkg::CREDIT_NUM));
    // start only from idle, then run to the end
    assign counter_incr = (en && counter_is_zero) || (!counter_is_zero && !counter_is_max);

    always_ff @(posedge clk) begin
        if (reset) begin
            counter <= '0;
            credit_out <= 1'b0;
        end else if (counter_incr) begin
            counter <= counter + 1'b1;
            credit_out <= 1'b1;
        end else begin
            credit_out <= 1'b0;
            if (counter_is_max) counter <= '0;  // burst done
        end
    end

endmodule

`default_nettype wire

// File: hw/crossbar.sv
`timescale 1ns/100ps
`default_nettype none

module crossbar (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [noc_pkg::P-1:0]       grant [noc_pkg::P],
    input  logic [noc_pkg::FLIT_W-1:0]  front_flit [noc_pkg::P],
    output logic [noc_pkg::FLIT_W-1:0]  flit_out [noc_pkg::P],
    output logic [noc_pkg::P-1:0]       flit_out_wr
);

    for (genvar o = 0; o < noc_pkg::P; o++) begin : g_out
        logic [noc_pkg::FLIT_W-1:0] sel_flit;
        logic [noc_pkg::P-1:0]      grant_q;

        // and-or mux over the one-hot grant
        always_comb begin
            sel_flit = '0;
            for (int i = 0; i < noc_pkg::P; i++) begin
                if (grant[o][i]) sel_flit = sel_flit | front_flit[i];
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                grant_q <= '0;
            end else begin
                grant_q <= grant[o];
            end
        end

        always_ff @(posedge clk) begin
            flit_out[o] <= sel_flit;  // stage 2 data
        end

        assign flit_out_wr[o] = |grant_q;

        a_grant_onehot : assert property (@(posedge clk) disable iff (reset) $onehot0(grant_q))
            else $error("crossbar: output %0d driven by more than one input", o);
    end

endmodule

`default_nettype wire

// File: hw/switch_alloc.sv
`timescale 1ns/100ps
`default_nettype none

module switch_alloc (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [noc_pkg::P-1:0]   req_valid,
    input  noc_pkg::port_e          req_port [noc_pkg::P],
    input  logic [noc_pkg::P-1:0]   req_tail,
    input  logic [noc_pkg::P-1:0]   credit_in,
    output logic [noc_pkg::P-1:0]   grant [noc_pkg::P],
    output logic [noc_pkg::P-1:0]   pop
);

    for (genvar o = 0; o < noc_pkg::P; o++) begin : g_out
        logic [noc_pkg::P-1:0]          eligible;
        logic [noc_pkg::P-1:0]          win;
        logic [noc_pkg::PORT_W-1:0]     win_idx;
        logic [noc_pkg::PORT_W-1:0]     ptr_q;    // last served input
        logic                           lock_q;   // packet in flight
        logic [noc_pkg::PORT_W-1:0]     owner_q;
        logic [router_pkg::CREDIT_W-1:0] credit_q;

        always_comb begin
            for (int i = 0; i < noc_pkg::P; i++) begin
                eligible[i] = req_valid[i] && (req_port[i] == noc_pkg::port_e'(o))
                              && (!lock_q || owner_q == noc_pkg::PORT_W'(i));
            end
        end

        // round robin starting after the last winner
        always_comb begin
            logic [noc_pkg::PORT_W-1:0] idx;
            win = '0;
            win_idx = ptr_q;
            idx = ptr_q;
            for (int k = 0; k < noc_pkg::P; k++) begin
                idx = (idx == noc_pkg::PORT_W'(noc_pkg::P - 1)) ? '0 : idx + 1'b1;
                if (win == '0 && eligible[idx] && credit_q != '0) begin
                    win[idx] = 1'b1;
                    win_idx = idx;
                end
            end
        end

        assign grant[o] = win;

        always_ff @(posedge clk) begin
            if (reset) begin
                ptr_q <= '0;
                lock_q <= 1'b0;
                owner_q <= '0;
                credit_q <= router_pkg::CREDIT_W'(router_pkg::BUF_DEPTH);
            end else begin
                if (win != '0) begin
                    ptr_q <= win_idx;
                    owner_q <= win_idx;
                    lock_q <= !req_tail[win_idx];  // released by the tail
                end
                if (win != '0 && !credit_in[o]) begin
                    credit_q <= credit_q - 1'b1;
                end else if (win == '0 && credit_in[o]) begin
                    credit_q <= credit_q + 1'b1;
                end
            end
        end

        // downstream never returns more than it was sent
        a_credit_range : assert property (@(posedge clk) disable iff (reset)
            credit_q <= router_pkg::CREDIT_W'(router_pkg::BUF_DEPTH))
            else $error("switch_alloc: credit counter out of range on output %0d", o);
    end

    // each input requests one output, so at most one grant per input
    always_comb begin
        pop = '0;
        for (int o = 0; o < noc_pkg::P; o++) begin
            pop = pop | grant[o];
        end
    end

endmodule

`default_nettype wire

// File: hw/input_port/input_port.sv
`timescale 1ns/100ps
`default_nettype none

module input_port (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [noc_pkg::COORD_W-1:0] cur_x,
    input  logic [noc_pkg::COORD_W-1:0] cur_y,
    input  logic [noc_pkg::FLIT_W-1:0]  flit_in,
    input  logic                        flit_in_wr,
    input  logic                        pop,
    output logic                        req_valid,
    output noc_pkg::port_e              req_port,
    output logic                        req_tail,
    output logic [noc_pkg::FLIT_W-1:0]  front_flit,
    output logic                        credit_pulse
);

    logic [noc_pkg::FLIT_W-1:0]    buf_mem [router_pkg::BUF_DEPTH];
    logic [router_pkg::PTR_W-1:0]  wr_ptr;
    logic [router_pkg::PTR_W-1:0]  rd_ptr;
    logic [router_pkg::CREDIT_W-1:0] count;  // occupancy
    logic                          empty;
    logic                          full;
    router_pkg::in_state_e         state;
    noc_pkg::port_e                route_q;  // route held for body and tail
    noc_pkg::port_e                xy_port;
    noc_pkg::flit_type_e           front_type;

    assign empty = (count == '0);
    assign full = (count == router_pkg::CREDIT_W'(router_pkg::BUF_DEPTH));

    assign front_flit = buf_mem[rd_ptr];
    assign front_type = noc_pkg::flit_type_e'(front_flit[noc_pkg::TYPE_LSB +: noc_pkg::TYPE_W]);

    xy_route route_i (
        .cur_x    (cur_x),
        .cur_y    (cur_y),
        .dest_x   (front_flit[noc_pkg::DX_LSB +: noc_pkg::COORD_W]),
        .dest_y   (front_flit[noc_pkg::DY_LSB +: noc_pkg::COORD_W]),
        .out_port (xy_port)
    );

    // a head at the front routes directly, later flits follow the latched port
    assign req_valid = !empty;
    assign req_port = (state == router_pkg::IN_IDLE) ? xy_port : route_q;
    assign req_tail = (front_type == noc_pkg::FLIT_TAIL) || (front_type == noc_pkg::FLIT_SINGLE);

    always_ff @(posedge clk) begin
        if (flit_in_wr) begin
            buf_mem[wr_ptr] <= flit_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (flit_in_wr) wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            if (flit_in_wr && !pop) begin
                count <= count + 1'b1;
            end else if (!flit_in_wr && pop) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= router_pkg::IN_IDLE;
            route_q <= noc_pkg::PORT_LOCAL;
            credit_pulse <= 1'b0;
        end else begin
            credit_pulse <= pop;  // one slot freed upstream
            if (state == router_pkg::IN_IDLE && !empty) begin
                route_q <= xy_port;
            end
            if (pop) begin
                if (state == router_pkg::IN_IDLE && front_type == noc_pkg::FLIT_HEAD) begin
                    state <= router_pkg::IN_ACTIVE;
                end else if (state == router_pkg::IN_ACTIVE
                             && front_type == noc_pkg::FLIT_TAIL) begin
                    state <= router_pkg::IN_IDLE;
                end
            end
        end
    end

    // upstream must hold a credit for every write
    a_no_overflow : assert property (@(posedge clk) disable iff (reset) !(flit_in_wr && full))
        else $error("input_port: write into full buffer");

    // allocator only grants a valid request
    a_no_underflow : assert property (@(posedge clk) disable iff (reset) !(pop && empty))
        else $error("input_port: pop from empty buffer");

endmodule

`default_nettype wire

// File: hw/input_port/xy_route.sv
`timescale 1ns/100ps
`default_nettype none

module xy_route (
    input  logic [noc_pkg::COORD_W-1:0] cur_x,
    input  logic [noc_pkg::COORD_W-1:0] cur_y,
    input  logic [noc_pkg::COORD_W-1:0] dest_x,
    input  logic [noc_pkg::COORD_W-1:0] dest_y,
    output noc_pkg::port_e              out_port
);

    // dimension order: x fully corrected before y
    always_comb begin
        if (dest_x > cur_x) begin
            out_port = noc_pkg::PORT_EAST;
        end else if (dest_x < cur_x) begin
            out_port = noc_pkg::PORT_WEST;
        end else if (dest_y > cur_y) begin
            out_port = noc_pkg::PORT_NORTH;
        end else if (dest_y < cur_y) begin
            out_port = noc_pkg::PORT_SOUTH;
        end else begin
            out_port = noc_pkg::PORT_LOCAL;  // arrived
        end
    end

endmodule

`default_nettype wire

// File: common/router_pkg.sv
`default_nettype none

package router_pkg;

    // input buffer depth, also the credits each output starts with
    localparam int BUF_DEPTH = 4;
    localparam int PTR_W = $clog2(BUF_DEPTH);

    // counts 0 .. BUF_DEPTH inclusive
    localparam int CREDIT_W = $clog2(BUF_DEPTH + 1);

    // pulses per release burst, enough to refill one buffer
    localparam int CREDIT_NUM = BUF_DEPTH;

    typedef enum logic {
        IN_IDLE,    // waiting for a head flit
        IN_ACTIVE   // inside a multi-flit packet
    } in_state_e;

endpackage

`default_nettype wire

// File: common/noc_pkg.sv
`default_nettype none

package noc_pkg;

    localparam int P = 5;           // local + four mesh neighbours
    localparam int COORD_W = 3;     // up to an 8x8 mesh
    localparam int PAYLOAD_W = 24;
    localparam int TYPE_W = 2;

    // flit layout, msb first: type, dest_x, dest_y, payload
    localparam int DY_LSB = PAYLOAD_W;
    localparam int DX_LSB = DY_LSB + COORD_W;
    localparam int TYPE_LSB = DX_LSB + COORD_W;
    localparam int FLIT_W = TYPE_LSB + TYPE_W;  // 32

    typedef enum logic [TYPE_W-1:0] {
        FLIT_HEAD,
        FLIT_BODY,
        FLIT_TAIL,
        FLIT_SINGLE     // head and tail in one flit
    } flit_type_e;

    localparam int PORT_W = 3;

    // east is +x, north is +y
    typedef enum logic [PORT_W-1:0] {
        PORT_LOCAL = 3'd0,
        PORT_EAST,
        PORT_NORTH,
        PORT_WEST,
        PORT_SOUTH
    } port_e;

endpackage

`default_nettype wire
